// ==== design/exec_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_alu
    import rv_pipe_pkg::*;
(
    input  alu_op_e         op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] y
);

    logic            lt;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;

    // add and sub wrap at 64 bits.
    assign sum  = a + b;
    assign diff = a - b;
    assign lt   = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            alu_add: begin
                y = sum;
            end
            alu_sub: begin
                y = diff;
            end
            alu_and: begin
                y = a & b;
            end
            alu_or: begin
                y = a | b;
            end
            alu_xor: begin
                y = a ^ b;
            end
            alu_slt: begin
                y = {{(xlen-1){1'b0}}, lt};
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/fwd_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module fwd_ctrl
    import rv_pipe_pkg::*;
(
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  stage_t                ex,
    input  stage_t                mem,
    input  stage_t                wb,
    output fwd_t                  fwd
);

    // a stage can supply rs only if it will really write that register.
    function automatic logic hit(
        input stage_t                s,
        input logic [reg_addr_w-1:0] rs
    );
        return s.valid && s.wen && (s.rd == rs) && (rs != '0);
    endfunction

    // newest producer wins.
    function automatic fwd_sel_e pick(
        input logic [reg_addr_w-1:0] rs,
        input stage_t                s_ex,
        input stage_t                s_mem,
        input stage_t                s_wb
    );
        fwd_sel_e sel;
        if (hit(s_ex, rs)) begin
            sel = src_ex;
        end else if (hit(s_mem, rs)) begin
            sel = src_mem;
        end else if (hit(s_wb, rs)) begin
            sel = src_wb;
        end else begin
            sel = src_rf;
        end
        return sel;
    endfunction

    always_comb begin
        fwd.a = pick(rs1, ex, mem, wb);
        fwd.b = pick(rs2, ex, mem, wb);
    end

endmodule

`default_nettype wire

// ==== design/id_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_decode
    import rv_pipe_pkg::*;
(
    input  instr_u instr,
    output dec_t   dec
);

    always_comb begin
        dec        = '0;
        dec.alu_op = alu_add;
        case (instr.r.opcode)
            opc_op: begin
                dec.rs1 = instr.r.rs1;
                dec.rs2 = instr.r.rs2;
                dec.rd  = instr.r.rd;
                dec.wen = 1'b1;
                case ({instr.r.funct7, instr.r.funct3})
                    {f7_base, f3_add_sub}: dec.alu_op = alu_add;
                    {f7_alt,  f3_add_sub}: dec.alu_op = alu_sub;
                    {f7_base, f3_slt}:     dec.alu_op = alu_slt;
                    {f7_base, f3_xor}:     dec.alu_op = alu_xor;
                    {f7_base, f3_or}:      dec.alu_op = alu_or;
                    {f7_base, f3_and}:     dec.alu_op = alu_and;
                    default:               dec.wen    = 1'b0;
                endcase
            end
            opc_op_imm: begin
                // rs2 stays zero so operand b never picks up a false match.
                dec.rs1     = instr.i.rs1;
                dec.rd      = instr.i.rd;
                dec.use_imm = 1'b1;
                dec.imm     = {{(xlen-12){instr.i.imm12[11]}}, instr.i.imm12};
                dec.wen     = 1'b1;
                case (instr.i.funct3)
                    f3_add_sub: dec.alu_op = alu_add;
                    f3_xor:     dec.alu_op = alu_xor;
                    f3_or:      dec.alu_op = alu_or;
                    f3_and:     dec.alu_op = alu_and;
                    default:    dec.wen    = 1'b0;
                endcase
            end
            default: begin
                // unknown opcode still flows down the pipe, without a write.
                dec.rd = instr.r.rd;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/int_pipe_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module int_pipe_top
    import rv_pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   issue,
    input  instr_u instr,
    output stage_t retire
);

    dec_t            dec;
    fwd_t            fwd;
    logic [xlen-1:0] rf_a;
    logic [xlen-1:0] rf_b;
    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic            rf_wen;

    logic            idex_valid;
    dec_t            idex_dec;
    logic [xlen-1:0] idex_opa;
    logic [xlen-1:0] idex_opb;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_y;

    stage_t          ex_s;
    stage_t          mem_q;
    stage_t          wb_q;

    // ========================================================================
    // decode and operand read
    // ========================================================================
    id_decode id_decode_i (
        .instr (instr),
        .dec   (dec)
    );

    assign rf_wen = wb_q.valid & wb_q.wen;

    reg_file reg_file_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .waddr  (wb_q.rd),
        .wen    (rf_wen),
        .wdata  (wb_q.result),
        .rdata1 (rf_a),
        .rdata2 (rf_b)
    );

    fwd_ctrl fwd_ctrl_i (
        .rs1 (dec.rs1),
        .rs2 (dec.rs2),
        .ex  (ex_s),
        .mem (mem_q),
        .wb  (wb_q),
        .fwd (fwd)
    );

    operand_mux operand_mux_i (
        .fwd     (fwd),
        .rf_a    (rf_a),
        .rf_b    (rf_b),
        .ex_res  (ex_s.result),
        .mem_res (mem_q.result),
        .wb_res  (wb_q.result),
        .opa     (opa),
        .opb     (opb)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex_valid <= 1'b0;
        end else begin
            idex_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        idex_dec <= dec;
        idex_opa <= opa;
        idex_opb <= opb;
    end

    // ========================================================================
    // execute, then mem and writeback registers
    // ========================================================================
    assign alu_b = idex_dec.use_imm ? idex_dec.imm : idex_opb;

    exec_alu exec_alu_i (
        .op (idex_dec.alu_op),
        .a  (idex_opa),
        .b  (alu_b),
        .y  (alu_y)
    );

    assign ex_s = '{valid: idex_valid, wen: idex_dec.wen, rd: idex_dec.rd, result: alu_y};

    // mem is a pass-through stage in this pipe.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_q <= '0;
            wb_q  <= '0;
        end else begin
            mem_q <= ex_s;
            wb_q  <= mem_q;
        end
    end

    assign retire = wb_q;

endmodule

`default_nettype wire

// ==== design/operand_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_mux
    import rv_pipe_pkg::*;
(
    input  fwd_t            fwd,
    input  logic [xlen-1:0] rf_a,
    input  logic [xlen-1:0] rf_b,
    input  logic [xlen-1:0] ex_res,
    input  logic [xlen-1:0] mem_res,
    input  logic [xlen-1:0] wb_res,
    output logic [xlen-1:0] opa,
    output logic [xlen-1:0] opb
);

    function automatic logic [xlen-1:0] steer(
        input fwd_sel_e        sel,
        input logic [xlen-1:0] rf,
        input logic [xlen-1:0] from_ex,
        input logic [xlen-1:0] from_mem,
        input logic [xlen-1:0] from_wb
    );
        logic [xlen-1:0] v;
        case (sel)
            src_ex:  v = from_ex;
            src_mem: v = from_mem;
            src_wb:  v = from_wb;
            default: v = rf;
        endcase
        return v;
    endfunction

    // each operand has its own select.
    assign opa = steer(fwd.a, rf_a, ex_res, mem_res, wb_res);
    assign opb = steer(fwd.b, rf_b, ex_res, mem_res, wb_res);

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file
    import rv_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic                  wen,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2
);

    // x0 has no storage.
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // reads are combinational, x0 reads as zero.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== design/rv_pipe_pkg.sv ====
`default_nettype none

package rv_pipe_pkg;

    // ========================================================================
    // widths and encodings
    // ========================================================================
    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    // ========================================================================
    // instruction word, seen as R-type or I-type
    // ========================================================================
    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    // ========================================================================
    // pipeline payloads
    // ========================================================================
    typedef struct packed {
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic [xlen-1:0]       imm;
        logic                  wen;
    } dec_t;

    typedef enum logic [1:0] {
        src_rf,
        src_ex,
        src_mem,
        src_wb
    } fwd_sel_e;

    typedef struct packed {
        fwd_sel_e a;
        fwd_sel_e b;
    } fwd_t;

    typedef struct packed {
        logic                  valid;
        logic                  wen;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
    } stage_t;

endpackage

`default_nettype wire

// ==== filelist.f ====
design/rv_pipe_pkg.sv
design/reg_file.sv
design/id_decode.sv
design/fwd_ctrl.sv
design/operand_mux.sv
design/exec_alu.sv
design/int_pipe_top.sv
tb/int_pipe_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module int_pipe_tb -f filelist.f -o int_pipe_sim

./obj_dir/int_pipe_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"

// ==== tb/int_pipe_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module int_pipe_tb
    import rv_pipe_pkg::*;
();

    typedef struct packed {
        logic [31:0] cycle;
        stage_t      st;
    } exp_t;

    logic            clk = 1'b0;
    logic            rst_n;
    logic            issue;
    instr_u          instr;
    stage_t          retire;
    logic [31:0]     cycle_cnt = '0;
    logic [xlen-1:0] mregs [0:31];
    exp_t            exp_q [$];
    integer          seed = 32'he695f2af;

    int_pipe_top int_pipe_top_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (issue),
        .instr  (instr),
        .retire (retire)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 32'd1;
    end

    // ========================================================================
    // checking and the register model
    // ========================================================================
    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("Error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] r_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc_op};
    endfunction

    function automatic logic [31:0] i_op(input logic [2:0] f3, input int rd, input int rs1,
                                         input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc_op_imm};
    endfunction

    // forwarding makes the pipe behave like sequential execution.
    task automatic model_step(input logic [31:0] w, output stage_t s);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        a = mregs[w[19:15]];
        b = (w[6:0] == opc_op_imm) ? {{52{w[31]}}, w[31:20]} : mregs[w[24:20]];
        s = '0;
        s.valid = 1'b1;
        s.rd = w[11:7];
        if (w[6:0] == opc_op) begin
            s.wen = 1'b1;
            case ({w[31:25], w[14:12]})
                {f7_base, f3_add_sub}: s.result = a + b;
                {f7_alt, f3_add_sub}:  s.result = a - b;
                {f7_base, f3_slt}:     s.result = {63'd0, $signed(a) < $signed(b)};
                {f7_base, f3_xor}:     s.result = a ^ b;
                {f7_base, f3_or}:      s.result = a | b;
                {f7_base, f3_and}:     s.result = a & b;
                default:               s.wen = 1'b0;
            endcase
        end else if (w[6:0] == opc_op_imm) begin
            s.wen = 1'b1;
            case (w[14:12])
                f3_add_sub: s.result = a + b;
                f3_xor:     s.result = a ^ b;
                f3_or:      s.result = a | b;
                f3_and:     s.result = a & b;
                default:    s.wen = 1'b0;
            endcase
        end
        if (s.wen && s.rd != 5'd0) begin
            mregs[s.rd] = s.result;
        end
    endtask

    // retire is due exactly three cycles after issue.
    task automatic check_retire();
        exp_t e;
        if (exp_q.size() != 0 && exp_q[0].cycle + 32'd3 == cycle_cnt) begin
            e = exp_q.pop_front();
            check_eq(64'(retire.valid), 64'd1, "retire.valid");
            check_eq(64'(retire.rd), 64'(e.st.rd), "retire.rd");
            check_eq(64'(retire.wen), 64'(e.st.wen), "retire.wen");
            if (e.st.wen) begin
                check_eq(retire.result, e.st.result, "retire.result");
            end
        end else begin
            check_eq(64'(retire.valid), 64'd0, "retire.valid with nothing due");
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            check_retire();
        end
    end

    // ========================================================================
    // stimulus
    // ========================================================================
    task automatic issue_instr(input logic [31:0] w);
        exp_t e;
        @(posedge clk);
        #2;
        issue = 1'b1;
        instr = w;
        e.cycle = cycle_cnt;
        model_step(w, e.st);
        exp_q.push_back(e);
    endtask

    task automatic bubble(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            issue = 1'b0;
            instr = '0;
        end
    endtask

    task automatic spaced(input logic [31:0] w);
        issue_instr(w);
        bubble(3);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        bubble(1);
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > 20) begin
                $display("pipeline did not retire every issued instruction in time");
                abort_run();
            end
        end
    endtask

    task automatic basic_ops();
        for (int i = 1; i < 32; i++) begin
            issue_instr(r_op(f7_base, f3_add_sub, i, i, 0));
        end
        bubble(3);
        spaced(i_op(f3_add_sub, 1, 0, 100));
        spaced(i_op(f3_add_sub, 2, 0, -7));
        spaced(r_op(f7_base, f3_add_sub, 3, 1, 2));
        spaced(r_op(f7_alt, f3_add_sub, 4, 2, 1));
        spaced(r_op(f7_base, f3_and, 5, 1, 2));
        spaced(r_op(f7_base, f3_or, 6, 1, 2));
        spaced(r_op(f7_base, f3_xor, 7, 1, 2));
        spaced(r_op(f7_base, f3_slt, 8, 2, 1));
        spaced(r_op(f7_base, f3_slt, 9, 1, 2));
        spaced(i_op(f3_xor, 10, 1, -1));
        spaced(i_op(f3_or, 11, 2, 240));
        spaced(i_op(f3_and, 12, 2, 255));
        drain();
    endtask

    task automatic forward_distance();
        issue_instr(i_op(f3_add_sub, 1, 0, 5));
        issue_instr(i_op(f3_add_sub, 1, 1, 3));
        issue_instr(r_op(f7_base, f3_add_sub, 2, 1, 1));
        issue_instr(i_op(f3_xor, 3, 0, -100));
        bubble(1);
        // x3 from mem, x2 from wb.
        issue_instr(r_op(f7_alt, f3_add_sub, 4, 3, 2));
        issue_instr(i_op(f3_add_sub, 5, 0, -3));
        bubble(2);
        issue_instr(r_op(f7_base, f3_slt, 6, 5, 4));
        drain();
    endtask

    task automatic dual_forward();
        issue_instr(i_op(f3_add_sub, 7, 0, 11));
        issue_instr(i_op(f3_add_sub, 8, 0, -22));
        issue_instr(i_op(f3_add_sub, 9, 0, 33));
        issue_instr(r_op(f7_alt, f3_add_sub, 10, 8, 9));
        issue_instr(r_op(f7_base, f3_xor, 14, 8, 10));
        issue_instr(i_op(f3_add_sub, 11, 0, 1));
        issue_instr(i_op(f3_add_sub, 11, 0, 2));
        issue_instr(r_op(f7_base, f3_add_sub, 12, 11, 11));
        issue_instr(i_op(f3_add_sub, 11, 0, 5));
        issue_instr(i_op(f3_add_sub, 11, 0, 6));
        bubble(1);
        issue_instr(r_op(f7_base, f3_add_sub, 12, 11, 0));
        drain();
    endtask

    task automatic x0_write();
        issue_instr(i_op(f3_add_sub, 0, 0, 55));
        issue_instr(r_op(f7_base, f3_add_sub, 13, 0, 0));
        issue_instr(i_op(f3_or, 0, 1, -1));
        bubble(1);
        issue_instr(r_op(f7_base, f3_or, 14, 0, 0));
        drain();
    endtask

    task automatic illegal_encodings();
        spaced(i_op(f3_add_sub, 15, 0, 77));
        issue_instr(r_op(f7_alt, f3_or, 15, 1, 2));
        issue_instr(i_op(f3_slt, 15, 1, 9));
        issue_instr({20'h12345, 5'd15, 7'b0000011});
        issue_instr(r_op(f7_base, f3_add_sub, 16, 15, 0));
        drain();
    endtask

    task automatic random_stream();
        logic [31:0] r;
        logic [31:0] w;
        for (int k = 0; k < 200; k++) begin
            r = $random(seed);
            case (r[13:12])
                2'd0, 2'd1: begin
                    w = r_op(r[14] ? f7_alt : f7_base, r[11:9], int'(r[2:0]),
                             int'(r[5:3]), int'(r[8:6]));
                end
                2'd2: begin
                    w = i_op(r[11:9], int'(r[2:0]), int'(r[5:3]), int'($signed(r[31:20])));
                end
                default: begin
                    w = {r[31:12], 2'b00, r[2:0], 7'b0000011};
                end
            endcase
            issue_instr(w);
        end
        drain();
    endtask

    initial begin
        rst_n = 1'b0;
        issue = 1'b0;
        instr = '0;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        basic_ops();
        forward_distance();
        dual_forward();
        x0_write();
        illegal_encodings();
        random_stream();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
